//--- tb.f
hw/ls_pkg.sv
hw/ls_ctrl.sv
hw/ls_mem_unit.sv
hw/ls_csr_file.sv
hw/ls_clint.sv
hw/ls_stage.sv
dv/ls_sram_model.sv
dv/ls_stage_tb.sv

//--- dv/ls_stage_tb.sv
`timescale 1ns/1ps
module ls_stage_tb;
    import ls_pkg::*;

    localparam int N_LOADS  = 40;
    localparam int N_STORES = 30;
    localparam int N_FWD    = 4;
    localparam int N_CSR    = 16;
    localparam int N_OPS    = N_LOADS + 2 * N_STORES + 2 * N_FWD + N_CSR + 20;
    localparam int LIMIT    = N_OPS * 8 + 200;

    localparam logic [31:0] NOP  = 32'h0000_0013;
    localparam logic [31:0] MRET = 32'h3020_0073;

    logic clk = 1'b0;
    logic reset;
    logic [63:0] pc, alu_res, rs2, wb_data, clint_wdata, sram_rd_data;
    instr_u instr, instr_last;
    logic ld_csr_hazard, trap, stall_n, if_stall_n, clint_wr, clint_rd;
    logic [3:0] clint_addr;
    logic sram_rd_valid, sram_wr_ok, ls_not_ok, in_intr, sram_rd_en, sram_wr_en;
    logic [63:0] ls_res, csr_data, mtvec, mepc, clint_rdata, sram_addr, sram_wr_data;
    logic [7:0] sram_wr_mask;
    logic [2:0] sram_size;

    logic [63:0] shadow [0:63];
    logic [63:0] exp_res;
    logic [2:0]  exp_size;
    logic [31:0] seed = 32'ha24e;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    always #2 clk = ~clk;

    ls_stage #(.TICK_DIV(4)) ls_stage_i (
        .clk(clk), .reset_i(reset), .pc_i(pc), .instr_i(instr), .instr_last_i(instr_last),
        .alu_res_i(alu_res), .rs2_i(rs2), .wb_data_i(wb_data), .ld_csr_hazard_i(ld_csr_hazard),
        .trap_i(trap), .stall_n_i(stall_n), .if_stall_n_i(if_stall_n),
        .clint_addr_i(clint_addr), .clint_wr_i(clint_wr), .clint_rd_i(clint_rd),
        .clint_wdata_i(clint_wdata), .sram_rd_valid_i(sram_rd_valid), .sram_wr_ok_i(sram_wr_ok),
        .sram_rd_data_i(sram_rd_data), .ls_res_o(ls_res), .ls_not_ok_o(ls_not_ok),
        .csr_data_o(csr_data), .mtvec_o(mtvec), .mepc_o(mepc), .in_intr_o(in_intr),
        .clint_rdata_o(clint_rdata), .sram_addr_o(sram_addr), .sram_rd_en_o(sram_rd_en),
        .sram_wr_en_o(sram_wr_en), .sram_wr_data_o(sram_wr_data),
        .sram_wr_mask_o(sram_wr_mask), .sram_size_o(sram_size)
    );

    ls_sram_model #(.SEED(32'ha24e)) ls_sram_model_i (
        .clk(clk), .reset_i(reset), .addr_i(sram_addr), .rd_en_i(sram_rd_en),
        .wr_en_i(sram_wr_en), .wr_data_i(sram_wr_data), .wr_mask_i(sram_wr_mask),
        .rd_valid_o(sram_rd_valid), .wr_ok_o(sram_wr_ok), .rd_data_o(sram_rd_data)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic get_rand(output logic [63:0] r);
        seed = lcg_step(seed);
        r[63:32] = seed;
        seed = lcg_step(seed);
        r[31:0] = seed;
    endtask

    // pick the accessed bytes, then sign extend the signed sizes
    function automatic logic [63:0] load_ref(input logic [63:0] word, input logic [2:0] off,
                                             input logic [2:0] op);
        int          nbytes;
        logic [63:0] val;
        nbytes = 1 << op[1:0];
        val = '0;
        for (int i = 0; i < nbytes; i++) begin
            val[8*i +: 8] = word[8*(off+i) +: 8];
        end
        if (!op[2] && nbytes < 8 && val[8*nbytes-1]) begin
            val = val | ~((64'd1 << (8 * nbytes)) - 64'd1);
        end
        return val;
    endfunction

    // log2 of the access width in bytes
    function automatic logic [2:0] size_ref(input logic [2:0] op);
        case (op)
            MEMOP_B, MEMOP_BU: return 3'd0;
            MEMOP_H, MEMOP_HU: return 3'd1;
            MEMOP_W, MEMOP_WU: return 3'd2;
            default:           return 3'd3;
        endcase
    endfunction

    function automatic logic [63:0] store_merge(input logic [63:0] word, input logic [2:0] off,
                                                input logic [1:0] size, input logic [63:0] data);
        for (int i = 0; i < (1 << size); i++) begin
            word[8*(off+i) +: 8] = data[8*i +: 8];
        end
        return word;
    endfunction

    function automatic logic [63:0] csr_ref(input logic [2:0] f3, input logic [63:0] old,
                                            input logic [63:0] src);
        case (f3[1:0])
            2'b01:   return src;
            2'b10:   return old | src;
            2'b11:   return old & ~src;
            default: return old;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic mem_access(input logic is_store, input logic [2:0] op, input logic [8:0] addr,
                              input logic [63:0] data, input logic fwd);
        logic [63:0] other;
        get_rand(other);
        @(posedge clk);
        alu_res <= 64'(addr);
        exp_size = size_ref(op);
        if (is_store) begin
            instr      <= {7'd0, 5'd7, 5'd1, op, 5'd0, OPC_STORE};
            instr_last <= {12'd0, 5'd0, 3'b000, fwd ? 5'd7 : 5'd9, 7'b0010011};  // addi
            rs2        <= fwd ? other : data;
            wb_data    <= fwd ? data : other;
            shadow[addr[8:3]] = store_merge(shadow[addr[8:3]], addr[2:0], op[1:0], data);
        end else begin
            instr      <= {12'd0, 5'd1, op, 5'd5, OPC_LOAD};
            instr_last <= NOP;
            exp_res = load_ref(shadow[addr[8:3]], addr[2:0], op);
        end
        do @(negedge clk); while (ls_not_ok);
        @(posedge clk);
        instr <= NOP;
    endtask

    task automatic csr_instr(input logic [2:0] f3, input logic [11:0] addr,
                             input logic [63:0] src, input logic hazard, output logic [63:0] old);
        @(posedge clk);
        instr         <= {addr, 5'd1, f3, 5'd2, OPC_SYSTEM};
        ld_csr_hazard <= hazard;
        alu_res       <= hazard ? ~src : src;
        wb_data       <= hazard ? src : ~src;
        @(negedge clk);
        old = csr_data;
        @(posedge clk);
        instr         <= NOP;
        ld_csr_hazard <= 1'b0;
        @(negedge clk);
    endtask

    // one check per load, in the cycle of the sram answer
    always @(negedge clk) begin
        if (!reset && instr.i.opcode == OPC_LOAD && !ls_not_ok) begin
            check_val("ls_res_o", ls_res, exp_res);
        end
        if (!reset && (sram_rd_en || sram_wr_en)) begin
            check_val("sram_size_o", 64'(sram_size), 64'(exp_size));   // while a request is out
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, the run did not complete", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        logic [63:0] r, src, old, sh_mtvec, sh_mepc, cmp, cur, last;
        logic [2:0]  op, f3;
        logic [8:0]  addr;
        logic        sel;
        int          pulses, post;
        bit          waiting;
        reset = 1'b1;
        pc = '0;
        instr = NOP;
        instr_last = NOP;
        alu_res = '0;
        rs2 = '0;
        wb_data = '0;
        ld_csr_hazard = 1'b0;
        trap = 1'b0;
        stall_n = 1'b1;
        if_stall_n = 1'b1;
        clint_addr = CLINT_MTIME;
        clint_wr = 1'b0;
        clint_rd = 1'b0;
        clint_wdata = '0;
        exp_res = '0;
        exp_size = '0;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = 64'h9e37_79b9_7f4a_7c15 * 64'(i + 1);
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        for (int n = 0; n < N_LOADS; n++) begin
            get_rand(r);
            op   = 3'(r[63:56] % 8'd7);
            addr = {r[50:45], 3'((r[42:40] >> op[1:0]) << op[1:0])};   // natural alignment
            mem_access(1'b0, op, addr, '0, 1'b0);
        end
        for (int n = 0; n < N_STORES + N_FWD; n++) begin
            get_rand(r);
            op   = {1'b0, r[63:62]};
            addr = {r[50:45], 3'((r[42:40] >> op[1:0]) << op[1:0])};
            get_rand(src);
            mem_access(1'b1, op, addr, src, n >= N_STORES);
            mem_access(1'b0, MEMOP_D, {addr[8:3], 3'b000}, '0, 1'b0);  // merged readback
        end

        get_rand(sh_mtvec);
        get_rand(sh_mepc);
        csr_instr(3'b001, CSR_MTVEC, sh_mtvec, 1'b0, old);
        csr_instr(3'b001, CSR_MEPC, sh_mepc, 1'b0, old);
        for (int n = 0; n < N_CSR; n++) begin
            get_rand(r);
            get_rand(src);
            f3  = 3'(r[63:56] % 8'd3) + 3'd1;
            sel = r[55];
            csr_instr(f3, sel ? CSR_MEPC : CSR_MTVEC, src, r[54], old);
            check_val("csr_data_o", old, sel ? sh_mepc : sh_mtvec);
            if (sel) begin
                sh_mepc = csr_ref(f3, sh_mepc, src);
                check_val("mepc_o", mepc, sh_mepc);
            end else begin
                sh_mtvec = csr_ref(f3, sh_mtvec, src);
                check_val("mtvec_o", mtvec, sh_mtvec);
            end
        end

        csr_instr(3'b010, CSR_MSTATUS, 64'h8, 1'b0, old);   // set mie
        @(posedge clk);
        pc   <= 64'h8000_1234;
        trap <= 1'b1;
        @(posedge clk);
        trap <= 1'b0;
        @(negedge clk);
        check_val("mepc_o", mepc, 64'h8000_1234);
        csr_instr(3'b010, CSR_MCAUSE, '0, 1'b0, old);
        check_val("csr_data_o", old, 64'd11);
        @(posedge clk);
        instr <= MRET;
        @(posedge clk);
        instr <= NOP;
        csr_instr(3'b010, CSR_MSTATUS, '0, 1'b0, old);
        check_val("csr_data_o", {62'd0, old[7], old[3]}, 64'd3);   // mpie and mie both set

        csr_instr(3'b010, CSR_MIE, 64'h80, 1'b0, old);      // mtie
        @(posedge clk);
        clint_rd   <= 1'b1;
        clint_addr <= CLINT_MTIME;
        @(negedge clk);
        last = clint_rdata;
        cmp  = last + 64'd10;
        @(posedge clk);
        clint_rd    <= 1'b0;
        clint_wr    <= 1'b1;
        clint_addr  <= CLINT_MTIMECMP;
        clint_wdata <= cmp;
        pc          <= 64'h8000_5678;
        @(posedge clk);
        clint_wr   <= 1'b0;
        clint_rd   <= 1'b1;
        clint_addr <= CLINT_MTIME;
        pulses  = 0;
        post    = 0;
        waiting = 1'b1;
        while (waiting) begin
            @(negedge clk);
            cur = clint_rdata;
            if (cur < last) report_error("mtime read back lower than the read before");
            last = cur;
            if (in_intr) begin
                pulses++;
                if (pulses == 1) check_val("mepc_o", mepc, 64'h8000_5678);
            end
            if (pulses == 0 && cur > cmp + 64'd1) begin
                report_error("timer interrupt was not taken before mtime passed mtimecmp");
                waiting = 1'b0;
            end
            if (pulses != 0) begin
                post++;
                if (post > 8) waiting = 1'b0;
            end
        end
        if (pulses > 1) report_error("timer interrupt was taken more than once");
        @(posedge clk);
        clint_rd <= 1'b0;
        csr_instr(3'b010, CSR_MCAUSE, '0, 1'b0, old);
        check_val("csr_data_o", old, 64'h8000_0000_0000_0007);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- dv/ls_sram_model.sv
`timescale 1ns/1ps
module ls_sram_model #(
    parameter logic [31:0] SEED = 32'ha24e
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic [63:0] addr_i,
    input  logic        rd_en_i,
    input  logic        wr_en_i,
    input  logic [63:0] wr_data_i,
    input  logic [7:0]  wr_mask_i,
    output logic        rd_valid_o,
    output logic        wr_ok_o,
    output logic [63:0] rd_data_o
);
    logic [63:0] mem [0:63];
    logic [63:0] merged;
    logic [31:0] lcg_state;
    logic        busy;
    logic [1:0]  wait_cnt;
    logic [5:0]  idx;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    assign idx = addr_i[8:3];

    initial begin
        rd_valid_o = 1'b0;
        wr_ok_o    = 1'b0;
        rd_data_o  = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 64'h9e37_79b9_7f4a_7c15 * 64'(i + 1);   // odd multiplier so every word differs
        end
    end

    always @(posedge clk) begin
        rd_valid_o <= 1'b0;
        wr_ok_o    <= 1'b0;
        if (reset_i) begin
            busy      <= 1'b0;
            wait_cnt  <= 2'd0;
            lcg_state <= SEED;
        end else if (busy) begin
            if (wait_cnt == 2'd0) begin
                busy <= 1'b0;
                if (rd_en_i) begin
                    rd_valid_o <= 1'b1;
                    rd_data_o  <= mem[idx];
                end
                if (wr_en_i) begin
                    merged = mem[idx];
                    for (int b = 0; b < 8; b++) begin
                        if (wr_mask_i[b]) merged[8*b +: 8] = wr_data_i[8*b +: 8];
                    end
                    mem[idx] <= merged;
                    wr_ok_o  <= 1'b1;
                end
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end else if ((rd_en_i || wr_en_i) && !rd_valid_o && !wr_ok_o) begin
            busy      <= 1'b1;                                   // answer in 1 to 3 cycles
            wait_cnt  <= 2'(lcg_state[23:16] % 8'd3);
            lcg_state <= lcg_step(lcg_state);
        end
    end

endmodule

//--- hw/ls_stage.sv
`timescale 1ns/1ps
module ls_stage #(
    parameter int TICK_DIV = 4
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [ls_pkg::XLEN-1:0] pc_i,
    input  ls_pkg::instr_u          instr_i,
    input  ls_pkg::instr_u          instr_last_i,
    input  logic [ls_pkg::XLEN-1:0] alu_res_i,
    input  logic [ls_pkg::XLEN-1:0] rs2_i,
    input  logic [ls_pkg::XLEN-1:0] wb_data_i,
    input  logic                    ld_csr_hazard_i,
    input  logic                    trap_i,
    input  logic                    stall_n_i,
    input  logic                    if_stall_n_i,
    input  logic [3:0]              clint_addr_i,
    input  logic                    clint_wr_i,
    input  logic                    clint_rd_i,
    input  logic [ls_pkg::XLEN-1:0] clint_wdata_i,
    input  logic                    sram_rd_valid_i,
    input  logic                    sram_wr_ok_i,
    input  logic [ls_pkg::XLEN-1:0] sram_rd_data_i,
    output logic [ls_pkg::XLEN-1:0] ls_res_o,
    output logic                    ls_not_ok_o,
    output logic [ls_pkg::XLEN-1:0] csr_data_o,
    output logic [ls_pkg::XLEN-1:0] mtvec_o,
    output logic [ls_pkg::XLEN-1:0] mepc_o,
    output logic                    in_intr_o,
    output logic [ls_pkg::XLEN-1:0] clint_rdata_o,
    output logic [ls_pkg::XLEN-1:0] sram_addr_o,
    output logic                    sram_rd_en_o,
    output logic                    sram_wr_en_o,
    output logic [ls_pkg::XLEN-1:0] sram_wr_data_o,
    output logic [7:0]              sram_wr_mask_o,
    output logic [2:0]              sram_size_o
);
    import ls_pkg::*;

    logic            mem_rd;
    logic            mem_wr;
    logic [2:0]      mem_op;
    logic [XLEN-1:0] store_data;
    logic [1:0]      csr_op;
    logic [11:0]     csr_addr;
    logic [XLEN-1:0] csr_src;
    logic            is_mret;
    logic            csr_stall_n;
    logic            timer_irq;

    ls_ctrl ls_ctrl_i (
        .instr_i         (instr_i),
        .instr_last_i    (instr_last_i),
        .rs2_i           (rs2_i),
        .wb_data_i       (wb_data_i),
        .alu_res_i       (alu_res_i),
        .ld_csr_hazard_i (ld_csr_hazard_i),
        .in_intr_i       (in_intr_o),
        .stall_n_i       (stall_n_i),
        .if_stall_n_i    (if_stall_n_i),
        .mem_rd_o        (mem_rd),
        .mem_wr_o        (mem_wr),
        .mem_op_o        (mem_op),
        .store_data_o    (store_data),
        .csr_op_o        (csr_op),
        .csr_addr_o      (csr_addr),
        .csr_src_o       (csr_src),
        .is_mret_o       (is_mret),
        .csr_stall_n_o   (csr_stall_n)
    );

    ls_mem_unit ls_mem_unit_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .mem_rd_i        (mem_rd),
        .mem_wr_i        (mem_wr),
        .mem_op_i        (mem_op),
        .addr_i          (alu_res_i),
        .store_data_i    (store_data),
        .sram_rd_valid_i (sram_rd_valid_i),
        .sram_wr_ok_i    (sram_wr_ok_i),
        .sram_rd_data_i  (sram_rd_data_i),
        .ls_res_o        (ls_res_o),
        .ls_not_ok_o     (ls_not_ok_o),
        .sram_addr_o     (sram_addr_o),
        .sram_rd_en_o    (sram_rd_en_o),
        .sram_wr_en_o    (sram_wr_en_o),
        .sram_wr_data_o  (sram_wr_data_o),
        .sram_wr_mask_o  (sram_wr_mask_o),
        .sram_size_o     (sram_size_o)
    );

    ls_csr_file ls_csr_file_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .pc_i        (pc_i),
        .csr_op_i    (csr_op),
        .csr_addr_i  (csr_addr),
        .csr_src_i   (csr_src),
        .is_mret_i   (is_mret),
        .trap_i      (trap_i),
        .stall_n_i   (csr_stall_n),
        .timer_irq_i (timer_irq),
        .csr_data_o  (csr_data_o),
        .mtvec_o     (mtvec_o),
        .mepc_o      (mepc_o),
        .in_intr_o   (in_intr_o)
    );

    ls_clint #(
        .TICK_DIV (TICK_DIV)
    ) ls_clint_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .addr_i      (clint_addr_i),
        .wr_i        (clint_wr_i),
        .rd_i        (clint_rd_i),
        .wdata_i     (clint_wdata_i),
        .rdata_o     (clint_rdata_o),
        .timer_irq_o (timer_irq)
    );

endmodule

//--- hw/ls_clint.sv
`timescale 1ns/1ps
module ls_clint #(
    parameter int TICK_DIV = 4
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [3:0]              addr_i,
    input  logic                    wr_i,
    input  logic                    rd_i,
    input  logic [ls_pkg::XLEN-1:0] wdata_i,
    output logic [ls_pkg::XLEN-1:0] rdata_o,
    output logic                    timer_irq_o
);
    import ls_pkg::*;

    localparam int CNT_W = $clog2(TICK_DIV + 1);

    logic [CNT_W-1:0] div_cnt;
    logic             tick;
    logic [XLEN-1:0]  mtime;
    logic [XLEN-1:0]  mtimecmp;

    assign tick = div_cnt == CNT_W'(TICK_DIV - 1);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            div_cnt  <= '0;
            mtime    <= '0;
            mtimecmp <= '1;                                   // no interrupt after reset
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (wr_i && (addr_i == CLINT_MTIME)) begin
                mtime <= wdata_i;                             // a write beats the tick
            end else if (tick) begin
                mtime <= mtime + 1'b1;
            end
            if (wr_i && (addr_i == CLINT_MTIMECMP)) begin
                mtimecmp <= wdata_i;
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        if (rd_i) begin
            case (addr_i)
                CLINT_MTIME:    rdata_o = mtime;
                CLINT_MTIMECMP: rdata_o = mtimecmp;
                default:        rdata_o = '0;
            endcase
        end
    end

    assign timer_irq_o = mtime >= mtimecmp;

endmodule

//--- hw/ls_csr_file.sv
`timescale 1ns/1ps
module ls_csr_file (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [ls_pkg::XLEN-1:0] pc_i,
    input  logic [1:0]              csr_op_i,
    input  logic [11:0]             csr_addr_i,
    input  logic [ls_pkg::XLEN-1:0] csr_src_i,
    input  logic                    is_mret_i,
    input  logic                    trap_i,
    input  logic                    stall_n_i,
    input  logic                    timer_irq_i,
    output logic [ls_pkg::XLEN-1:0] csr_data_o,
    output logic [ls_pkg::XLEN-1:0] mtvec_o,
    output logic [ls_pkg::XLEN-1:0] mepc_o,
    output logic                    in_intr_o
);
    import ls_pkg::*;

    localparam logic [XLEN-1:0] CAUSE_ECALL = 64'd11;

    logic            mstatus_mie;
    logic            mstatus_mpie;
    logic            mie_mtie;
    logic            in_intr_q;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] csr_new;
    logic            take_intr;
    logic            take_trap;
    logic            csr_wr;

    // mpp reads as machine mode
    assign mstatus = {51'b0, 2'b11, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
    assign mie     = {56'b0, mie_mtie, 7'b0};
    assign mip     = {56'b0, timer_irq_i, 7'b0};                // mtip is read only

    always_comb begin
        case (csr_addr_i)
            CSR_MSTATUS: csr_data_o = mstatus;
            CSR_MIE:     csr_data_o = mie;
            CSR_MIP:     csr_data_o = mip;
            CSR_MTVEC:   csr_data_o = mtvec;
            CSR_MEPC:    csr_data_o = mepc;
            CSR_MCAUSE:  csr_data_o = mcause;
            default:     csr_data_o = '0;
        endcase
    end

    always_comb begin
        case (csr_op_i)
            CSR_OP_RW: csr_new = csr_src_i;
            CSR_OP_RS: csr_new = csr_data_o | csr_src_i;
            CSR_OP_RC: csr_new = csr_data_o & ~csr_src_i;
            default:   csr_new = csr_data_o;
        endcase
    end

    assign take_intr = stall_n_i && mstatus_mie && mie_mtie && timer_irq_i;
    assign take_trap = stall_n_i && trap_i;
    // an instruction that is interrupted or traps does not write its csr
    assign csr_wr    = stall_n_i && (csr_op_i != CSR_OP_NONE) && !take_intr && !take_trap;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_mtie     <= 1'b0;
            in_intr_q    <= 1'b0;
        end else begin
            in_intr_q <= take_intr;
            if (take_intr || take_trap) begin
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
            end else if (is_mret_i && stall_n_i) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end else if (csr_wr && (csr_addr_i == CSR_MSTATUS)) begin
                mstatus_mie  <= csr_new[3];
                mstatus_mpie <= csr_new[7];
            end
            if (csr_wr && (csr_addr_i == CSR_MIE)) begin
                mie_mtie <= csr_new[7];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_intr || take_trap) begin
            mepc   <= pc_i;
            mcause <= take_intr ? CAUSE_TIMER : CAUSE_ECALL;  // interrupt wins
        end else if (csr_wr) begin
            case (csr_addr_i)
                CSR_MTVEC:  mtvec  <= csr_new;
                CSR_MEPC:   mepc   <= csr_new;
                CSR_MCAUSE: mcause <= csr_new;
                default:    ;
            endcase
        end
    end

    assign mtvec_o   = mtvec;
    assign mepc_o    = mepc;
    assign in_intr_o = in_intr_q;

    // mie is dropped on entry, so the interrupt cannot be taken twice in a row
    a_intr_pulse: assert property (@(posedge clk) disable iff (reset_i)
        in_intr_o |=> !in_intr_o);

endmodule

//--- hw/ls_mem_unit.sv
`timescale 1ns/1ps
module ls_mem_unit (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    mem_rd_i,
    input  logic                    mem_wr_i,
    input  logic [2:0]              mem_op_i,
    input  logic [ls_pkg::XLEN-1:0] addr_i,
    input  logic [ls_pkg::XLEN-1:0] store_data_i,
    input  logic                    sram_rd_valid_i,
    input  logic                    sram_wr_ok_i,
    input  logic [ls_pkg::XLEN-1:0] sram_rd_data_i,
    output logic [ls_pkg::XLEN-1:0] ls_res_o,
    output logic                    ls_not_ok_o,
    output logic [ls_pkg::XLEN-1:0] sram_addr_o,
    output logic                    sram_rd_en_o,
    output logic                    sram_wr_en_o,
    output logic [ls_pkg::XLEN-1:0] sram_wr_data_o,
    output logic [7:0]              sram_wr_mask_o,
    output logic [2:0]              sram_size_o
);
    import ls_pkg::*;

    localparam int KEY_W = 2 * XLEN + 4;

    logic [2:0]       byte_off;
    logic [KEY_W-1:0] req_key;
    logic [KEY_W-1:0] done_key;
    logic             done_q;
    logic             any_req;
    logic             req;
    logic             answer;
    logic [XLEN-1:0]  rd_shift;
    logic [XLEN-1:0]  ld_ext;
    logic [XLEN-1:0]  ls_res_q;

    assign byte_off = addr_i[2:0];
    assign any_req  = mem_rd_i || mem_wr_i;
    assign answer   = sram_rd_valid_i || sram_wr_ok_i;

    // a held instruction that already got its answer is not issued again
    assign req_key = {mem_wr_i, mem_op_i, addr_i, store_data_i};
    assign req     = any_req && !(done_q && (req_key == done_key));

    assign sram_addr_o    = {addr_i[XLEN-1:3], 3'b000};
    assign sram_rd_en_o   = mem_rd_i && req;
    assign sram_wr_en_o   = mem_wr_i && req;
    assign sram_size_o    = {1'b0, mem_op_i[1:0]};           // log2 of bytes
    assign sram_wr_data_o = store_data_i << {byte_off, 3'b000};
    assign ls_not_ok_o    = req && !answer;

    always_comb begin
        case (mem_op_i[1:0])
            MEMOP_B[1:0]: sram_wr_mask_o = 8'h01 << byte_off;
            MEMOP_H[1:0]: sram_wr_mask_o = 8'h03 << byte_off;
            MEMOP_W[1:0]: sram_wr_mask_o = 8'h0f << byte_off;
            default:      sram_wr_mask_o = 8'hff;
        endcase
    end

    assign rd_shift = sram_rd_data_i >> {byte_off, 3'b000};

    always_comb begin
        case (mem_op_i)
            MEMOP_B:  ld_ext = {{(XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
            MEMOP_H:  ld_ext = {{(XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
            MEMOP_W:  ld_ext = {{(XLEN-32){rd_shift[31]}}, rd_shift[31:0]};
            MEMOP_BU: ld_ext = {{(XLEN-8){1'b0}}, rd_shift[7:0]};
            MEMOP_HU: ld_ext = {{(XLEN-16){1'b0}}, rd_shift[15:0]};
            MEMOP_WU: ld_ext = {{(XLEN-32){1'b0}}, rd_shift[31:0]};
            default:  ld_ext = rd_shift;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            done_q <= 1'b0;
        end else if (answer) begin
            done_q <= 1'b1;
        end else if (!any_req || (req_key != done_key)) begin
            done_q <= 1'b0;                                   // next instruction
        end
    end

    always_ff @(posedge clk) begin
        if (answer) begin
            done_key <= req_key;
        end
        if (sram_rd_valid_i) begin
            ls_res_q <= ld_ext;
        end
    end

    assign ls_res_o = sram_rd_valid_i ? ld_ext : ls_res_q;

    // the sram only answers a request that is still being issued
    a_no_stray_answer: assert property (@(posedge clk) disable iff (reset_i)
        (sram_rd_valid_i |-> sram_rd_en_o) and (sram_wr_ok_i |-> sram_wr_en_o));

endmodule

//--- hw/ls_ctrl.sv
`timescale 1ns/1ps
module ls_ctrl (
    input  ls_pkg::instr_u          instr_i,
    input  ls_pkg::instr_u          instr_last_i,
    input  logic [ls_pkg::XLEN-1:0] rs2_i,
    input  logic [ls_pkg::XLEN-1:0] wb_data_i,
    input  logic [ls_pkg::XLEN-1:0] alu_res_i,
    input  logic                    ld_csr_hazard_i,
    input  logic                    in_intr_i,
    input  logic                    stall_n_i,
    input  logic                    if_stall_n_i,
    output logic                    mem_rd_o,
    output logic                    mem_wr_o,
    output logic [2:0]              mem_op_o,
    output logic [ls_pkg::XLEN-1:0] store_data_o,
    output logic [1:0]              csr_op_o,
    output logic [11:0]             csr_addr_o,
    output logic [ls_pkg::XLEN-1:0] csr_src_o,
    output logic                    is_mret_o,
    output logic                    csr_stall_n_o
);
    import ls_pkg::*;

    localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
    localparam logic [11:0] MRET_IMM   = 12'h302;

    logic is_load;
    logic is_store;
    logic is_system;
    logic last_wr_rd;
    logic fwd_store;

    assign is_load   = instr_i.i.opcode == OPC_LOAD;
    assign is_store  = instr_i.s.opcode == OPC_STORE;
    assign is_system = instr_i.i.opcode == OPC_SYSTEM;

    assign mem_rd_o = is_load;
    assign mem_wr_o = is_store;
    assign mem_op_o = instr_i.i.funct3;                  // funct3 sits in the same bits for stores

    // stores and branches have no rd field and x0 is never forwarded
    assign last_wr_rd = (instr_last_i.i.opcode != OPC_STORE)
                     && (instr_last_i.i.opcode != OPC_BRANCH)
                     && (instr_last_i.i.rd != 5'd0);
    assign fwd_store  = is_store && last_wr_rd && (instr_last_i.i.rd == instr_i.s.rs2);

    assign store_data_o = fwd_store ? wb_data_i : rs2_i;

    assign csr_op_o   = is_system ? instr_i.i.funct3[1:0] : CSR_OP_NONE;
    assign csr_addr_o = instr_i.i.imm;
    assign is_mret_o  = is_system && (instr_i.i.funct3 == 3'b000) && (instr_i.i.imm == MRET_IMM);

    // load-to-csr hazard takes the wb result instead of the register value
    assign csr_src_o = ld_csr_hazard_i ? wb_data_i : alu_res_i;

    // an interrupt may meet a load-use stall and then the fetch side decides
    assign csr_stall_n_o = in_intr_i ? if_stall_n_i : stall_n_i;

endmodule

//--- hw/ls_pkg.sv
package ls_pkg;

    localparam int XLEN = 64;
    localparam int ILEN = 32;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 of loads and stores
    localparam logic [2:0] MEMOP_B  = 3'b000;
    localparam logic [2:0] MEMOP_H  = 3'b001;
    localparam logic [2:0] MEMOP_W  = 3'b010;
    localparam logic [2:0] MEMOP_D  = 3'b011;
    localparam logic [2:0] MEMOP_BU = 3'b100;
    localparam logic [2:0] MEMOP_HU = 3'b101;
    localparam logic [2:0] MEMOP_WU = 3'b110;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MIE     = 12'h304;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;
    localparam logic [11:0] CSR_MIP     = 12'h344;

    localparam logic [1:0] CSR_OP_NONE = 2'b00; // same as funct3[1:0] of csrrw/s/c
    localparam logic [1:0] CSR_OP_RW   = 2'b01;
    localparam logic [1:0] CSR_OP_RS   = 2'b10;
    localparam logic [1:0] CSR_OP_RC   = 2'b11;

    localparam logic [XLEN-1:0] CAUSE_TIMER = {1'b1, 63'd7};

    localparam logic [3:0] CLINT_MTIME    = 4'h0;
    localparam logic [3:0] CLINT_MTIMECMP = 4'h8;

    typedef union packed {
        struct packed {
            logic [11:0] imm;      // also the csr address
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0]  imm_hi;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } s;
    } instr_u;

endpackage
